//--- Makefile
VERILATOR := verilator
FLAGS     := --binary --timing --assert
TOP       := cpuTb
FILELIST  := verilog.f
OBJDIR    := obj_dir
LOG       := sim.log
PASSMSG   := ** PASS **

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only --timing --assert -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	grep -qF '$(PASSMSG)' $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

//--- rtl/alu.sv
`default_nettype none

module alu (
   input  cpuPkg::ctrlT                      ctrl,
   input  wire logic [cpuPkg::dataWidth-1:0] rsData,
   input  wire logic [cpuPkg::dataWidth-1:0] rtData,
   input  wire logic [cpuPkg::dataWidth-1:0] immFive,
   input  wire logic [cpuPkg::dataWidth-1:0] immEight,
   output logic      [cpuPkg::dataWidth-1:0] result,
   output logic                              takeBranch
);

   import cpuPkg::*;

   logic [dataWidth-1:0] opA;
   logic [dataWidth-1:0] opB;
   logic [dataWidth-1:0] bSel;
   logic                 rsZero;

   ////////////////////////////////////////
   // Operand select
   ////////////////////////////////////////

   always_comb begin
      case (ctrl.bSrc)
         bImm5:   bSel = immFive;
         bImm8:   bSel = immEight;
         default: bSel = rtData;
      endcase
   end

   // Inversion for subtract and and-not
   assign opA = ctrl.invA ? ~rsData : rsData;
   assign opB = ctrl.invB ? ~bSel : bSel;

   ////////////////////////////////////////
   // Operation
   ////////////////////////////////////////

   always_comb begin
      case (ctrl.aluOp)
         aluXor:  result = opA ^ opB;
         // B already inverted by decode
         aluAndn: result = opA & opB;
         // Add also gives the LD and ST address
         default: result = opA + opB + dataWidth'(ctrl.cin);
      endcase
   end

   // Branch condition on Rs alone
   assign rsZero = (rsData == '0);
   assign takeBranch = ctrl.isBranch & (ctrl.brOnZero == rsZero);

endmodule

`default_nettype wire

//--- rtl/cpuPkg.sv
`default_nettype none

package cpuPkg;

   ////////////////////////////////////////
   // Fixed sizes
   ////////////////////////////////////////

   // One word is a register, a data value and a word address
   localparam int dataWidth = 16;
   localparam int regSelWidth = 3;
   localparam int numRegs = 1 << regSelWidth;

   ////////////////////////////////////////
   // Encodings
   ////////////////////////////////////////

   // Instruction opcodes in bits 15:11
   typedef enum logic [4:0] {
      opHalt  = 5'b00000,
      opNop   = 5'b00001,
      opJ     = 5'b00100,
      opJal   = 5'b00110,
      opAddi  = 5'b01000,
      opSubi  = 5'b01001,
      opXori  = 5'b01010,
      opAndni = 5'b01011,
      opBeqz  = 5'b01100,
      opBnez  = 5'b01101,
      opSt    = 5'b10000,
      opLd    = 5'b10001,
      opLbi   = 5'b11000,
      opAluR  = 5'b11011
   } opcodeT;

   // Subtraction is an add with A inverted and carry in set
   typedef enum logic [1:0] {aluAdd, aluXor, aluAndn} aluOpT;

   // Destination field of the register write
   typedef enum logic [1:0] {dstRt, dstRd, dstR7, dstRs} regDstT;

   // Write-back source
   typedef enum logic [1:0] {srcAlu, srcMem, srcPcLink, srcImm} regSrcT;

   // ALU B operand
   typedef enum logic [1:0] {bReg, bImm5, bImm8} bSrcT;

   typedef enum logic [2:0] {
      stFetch, stDecode, stExecute, stMemory, stWriteback, stHalted
   } stateT;

   ////////////////////////////////////////
   // Bundles
   ////////////////////////////////////////

   // Decoded controls of one instruction
   typedef struct packed {
      aluOpT  aluOp;
      logic   invA;
      logic   invB;
      logic   cin;
      bSrcT   bSrc;
      logic   memWrt;
      logic   memRd;
      logic   regWrt;
      regDstT regDst;
      regSrcT regSrc;
      logic   isBranch;
      logic   brOnZero;
      logic   isJump;
      logic   immSrc;     // 1 picks the 11-bit offset for the PC
      logic   halt;
   } ctrlT;

   // Master side of the Wishbone classic bus
   typedef struct packed {
      logic                 cyc;
      logic                 stb;
      logic                 we;
      logic [dataWidth-1:0] adr;
      logic [dataWidth-1:0] datWr;
   } wbReqT;

   // Slave side
   typedef struct packed {
      logic                 ack;
      logic [dataWidth-1:0] datRd;
   } wbRspT;

endpackage

`default_nettype wire

//--- rtl/cpuSequencer.sv
`default_nettype none

module cpuSequencer (
   input  wire logic                           clk,
   input  wire logic                           arstN,
   input  cpuPkg::ctrlT                        ctrl,
   input  wire logic [cpuPkg::dataWidth-1:0]   aluResult,
   input  wire logic                           takeBranch,
   input  wire logic [cpuPkg::dataWidth-1:0]   rtData,
   input  wire logic [cpuPkg::dataWidth-1:0]   immEight,
   input  wire logic [cpuPkg::dataWidth-1:0]   immEleven,
   input  wire logic                           busDone,
   input  wire logic [cpuPkg::dataWidth-1:0]   busRdData,
   output logic                                busStart,
   output logic                                busWe,
   output logic      [cpuPkg::dataWidth-1:0]   busAdr,
   output logic      [cpuPkg::dataWidth-1:0]   busWrData,
   output logic      [cpuPkg::dataWidth-1:0]   instr,
   output logic      [cpuPkg::regSelWidth-1:0] wrSel,
   output logic      [cpuPkg::dataWidth-1:0]   wrData,
   output logic                                wrEn,
   output logic                                halted
);

   import cpuPkg::*;

   stateT                state;
   logic [dataWidth-1:0] pc;
   logic [dataWidth-1:0] ir;
   logic [dataWidth-1:0] resultReg;
   logic [dataWidth-1:0] pcPlusOne;
   logic [dataWidth-1:0] pcOffset;
   logic [dataWidth-1:0] pcTarget;
   logic                 busWait;
   logic                 redirect;

   ////////////////////////////////////////
   // Next PC
   ////////////////////////////////////////

   // Word addresses so sequential flow is plus one
   assign pcPlusOne = pc + dataWidth'(1);
   assign pcOffset = ctrl.immSrc ? immEleven : immEight;
   assign redirect = ctrl.isJump | takeBranch;
   assign pcTarget = redirect ? pcPlusOne + pcOffset : pcPlusOne;

   ////////////////////////////////////////
   // State machine
   ////////////////////////////////////////

   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         state <= stFetch;
         pc <= '0;
         busWait <= 1'b0;
      end else begin
         // One bus request outstanding at most
         if (busStart) begin
            busWait <= 1'b1;
         end else if (busDone) begin
            busWait <= 1'b0;
         end
         case (state)
            stFetch:     if (busDone) state <= stDecode;
            stDecode:    state <= ctrl.halt ? stHalted : stExecute;
            stExecute: begin
               pc <= pcTarget;
               state <= (ctrl.memRd | ctrl.memWrt) ? stMemory : stWriteback;
            end
            stMemory:    if (busDone) state <= stWriteback;
            stWriteback: state <= stFetch;
            // Left only through reset
            stHalted:    state <= stHalted;
            default:     state <= stFetch;
         endcase
      end
   end

   // Instruction and result registers
   always_ff @(posedge clk) begin
      if ((state == stFetch) && busDone) begin
         ir <= busRdData;
      end
      if (state == stExecute) begin
         resultReg <= (ctrl.regSrc == srcPcLink) ? pcPlusOne : aluResult;
      end
   end

   // Bus request, fetch uses PC and memory uses the ALU address
   assign busStart = ((state == stFetch) || (state == stMemory)) && !busWait;
   assign busWe = (state == stMemory) & ctrl.memWrt;
   assign busAdr = (state == stMemory) ? resultReg : pc;
   assign busWrData = rtData;

   assign instr = ir;

   always_comb begin
      case (ctrl.regDst)
         dstRd:   wrSel = ir[4:2];
         dstR7:   wrSel = 3'd7;
         dstRs:   wrSel = ir[10:8];
         default: wrSel = ir[7:5];
      endcase
      case (ctrl.regSrc)
         srcMem:  wrData = busRdData;
         srcImm:  wrData = immEight;
         // Link value sits in the result register too
         default: wrData = resultReg;
      endcase
   end

   // Decode masks this with regWrt
   assign wrEn = (state == stWriteback);
   assign halted = (state == stHalted);

endmodule

`default_nettype wire

//--- rtl/cpuTop.sv
`default_nettype none

module cpuTop (
   input  wire logic     clk,
   input  wire logic     arstN,
   output cpuPkg::wbReqT wbReq,
   input  cpuPkg::wbRspT wbRsp,
   output logic          halted
);

   import cpuPkg::*;

   ctrlT                   ctrl;
   logic [dataWidth-1:0]   instr;
   logic [dataWidth-1:0]   rsData;
   logic [dataWidth-1:0]   rtData;
   logic [dataWidth-1:0]   immFive;
   logic [dataWidth-1:0]   immEight;
   logic [dataWidth-1:0]   immEleven;
   logic [dataWidth-1:0]   aluResult;
   logic                   takeBranch;
   logic [regSelWidth-1:0] wrSel;
   logic [dataWidth-1:0]   wrData;
   logic                   wrEn;
   // Sequencer to bus master
   logic                   busStart;
   logic                   busWe;
   logic [dataWidth-1:0]   busAdr;
   logic [dataWidth-1:0]   busWrData;
   logic                   busDone;
   logic [dataWidth-1:0]   busRdData;

   cpuSequencer i_cpuSequencer (
      .clk, .arstN, .ctrl, .aluResult, .takeBranch, .rtData, .immEight, .immEleven,
      .busDone, .busRdData, .busStart, .busWe, .busAdr, .busWrData,
      .instr, .wrSel, .wrData, .wrEn, .halted
   );

   decode i_decode (
      .clk, .arstN, .instr, .wrSel, .wrData, .wrEn,
      .ctrl, .rsData, .rtData, .immFive, .immEight, .immEleven
   );

   alu i_alu (
      .ctrl, .rsData, .rtData, .immFive, .immEight,
      .result (aluResult),
      .takeBranch
   );

   // Single Wishbone port for fetch and data
   wbMaster i_wbMaster (
      .clk, .arstN, .busStart, .busWe, .busAdr, .busWrData,
      .busDone, .busRdData, .wbReq, .wbRsp
   );

endmodule

`default_nettype wire

//--- rtl/decode.sv
`default_nettype none

module decode (
   input  wire logic                           clk,
   input  wire logic                           arstN,
   input  wire logic [cpuPkg::dataWidth-1:0]   instr,
   input  wire logic [cpuPkg::regSelWidth-1:0] wrSel,
   input  wire logic [cpuPkg::dataWidth-1:0]   wrData,
   input  wire logic                           wrEn,
   output cpuPkg::ctrlT                        ctrl,
   output logic      [cpuPkg::dataWidth-1:0]   rsData,
   output logic      [cpuPkg::dataWidth-1:0]   rtData,
   output logic      [cpuPkg::dataWidth-1:0]   immFive,
   output logic      [cpuPkg::dataWidth-1:0]   immEight,
   output logic      [cpuPkg::dataWidth-1:0]   immEleven
);

   import cpuPkg::*;

   opcodeT     opcode;
   logic [1:0] func;
   logic       zeroExt;

   assign opcode = opcodeT'(instr[15:11]);
   // Function bits of the register-register group
   assign func = instr[1:0];

   ////////////////////////////////////////
   // Control decode
   ////////////////////////////////////////

   always_comb begin
      // Defaults describe a NOP
      ctrl = '0;
      ctrl.aluOp = aluAdd;
      ctrl.bSrc = bReg;
      ctrl.regDst = dstRt;
      ctrl.regSrc = srcAlu;
      case (opcode)
         opHalt: ctrl.halt = 1'b1;
         opAddi: begin
            ctrl.bSrc = bImm5;
            ctrl.regWrt = 1'b1;
         end
         // Immediate minus Rs
         opSubi: begin
            ctrl.bSrc = bImm5;
            ctrl.invA = 1'b1;
            ctrl.cin = 1'b1;
            ctrl.regWrt = 1'b1;
         end
         opXori: begin
            ctrl.aluOp = aluXor;
            ctrl.bSrc = bImm5;
            ctrl.regWrt = 1'b1;
         end
         opAndni: begin
            ctrl.aluOp = aluAndn;
            ctrl.bSrc = bImm5;
            ctrl.invB = 1'b1;
            ctrl.regWrt = 1'b1;
         end
         // Address is Rs plus imm5 for both memory ops
         opSt: begin
            ctrl.bSrc = bImm5;
            ctrl.memWrt = 1'b1;
         end
         opLd: begin
            ctrl.bSrc = bImm5;
            ctrl.memRd = 1'b1;
            ctrl.regWrt = 1'b1;
            ctrl.regSrc = srcMem;
         end
         // LBI writes its own Rs field
         opLbi: begin
            ctrl.bSrc = bImm8;
            ctrl.regWrt = 1'b1;
            ctrl.regDst = dstRs;
            ctrl.regSrc = srcImm;
         end
         opBeqz: begin
            ctrl.isBranch = 1'b1;
            ctrl.brOnZero = 1'b1;
         end
         opBnez: ctrl.isBranch = 1'b1;
         opJ: begin
            ctrl.isJump = 1'b1;
            ctrl.immSrc = 1'b1;
         end
         // JAL links PC plus one into R7
         opJal: begin
            ctrl.isJump = 1'b1;
            ctrl.immSrc = 1'b1;
            ctrl.regWrt = 1'b1;
            ctrl.regDst = dstR7;
            ctrl.regSrc = srcPcLink;
         end
         opAluR: begin
            ctrl.regWrt = 1'b1;
            ctrl.regDst = dstRd;
            case (func)
               2'b00: ctrl.aluOp = aluAdd;
               // Rt minus Rs
               2'b01: begin
                  ctrl.invA = 1'b1;
                  ctrl.cin = 1'b1;
               end
               2'b10: ctrl.aluOp = aluXor;
               default: begin
                  ctrl.aluOp = aluAndn;
                  ctrl.invB = 1'b1;
               end
            endcase
         end
         // NOP and unsupported opcodes keep the defaults
         default: ;
      endcase
   end

   ////////////////////////////////////////
   // Immediates
   ////////////////////////////////////////

   // Logic immediates are zero extended
   assign zeroExt = (opcode == opXori) || (opcode == opAndni);

   assign immFive = zeroExt ? {11'b0, instr[4:0]} : {{11{instr[4]}}, instr[4:0]};
   assign immEight = zeroExt ? {8'b0, instr[7:0]} : {{8{instr[7]}}, instr[7:0]};
   assign immEleven = {{5{instr[10]}}, instr[10:0]};

   // Rs on port A, Rt on port B
   regFile i_regFile (
      .clk     (clk),
      .arstN   (arstN),
      .rdSelA  (instr[10:8]),
      .rdSelB  (instr[7:5]),
      .wrSel   (wrSel),
      .wrData  (wrData),
      .wrEn    (wrEn & ctrl.regWrt),
      .rdDataA (rsData),
      .rdDataB (rtData)
   );

endmodule

`default_nettype wire

//--- rtl/regFile.sv
`default_nettype none

module regFile (
   input  wire logic                           clk,
   input  wire logic                           arstN,
   input  wire logic [cpuPkg::regSelWidth-1:0] rdSelA,
   input  wire logic [cpuPkg::regSelWidth-1:0] rdSelB,
   input  wire logic [cpuPkg::regSelWidth-1:0] wrSel,
   input  wire logic [cpuPkg::dataWidth-1:0]   wrData,
   input  wire logic                           wrEn,
   output logic      [cpuPkg::dataWidth-1:0]   rdDataA,
   output logic      [cpuPkg::dataWidth-1:0]   rdDataB
);

   import cpuPkg::*;

   // Eight general registers, R7 doubles as the link register
   logic [dataWidth-1:0] regs [numRegs];

   // All registers start at zero
   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         for (int i = 0; i < numRegs; i++) begin
            regs[i] <= '0;
         end
      end else if (wrEn) begin
         regs[wrSel] <= wrData;
      end
   end

   // Combinational reads
   // No write bypass since reads and writes never share a state
   assign rdDataA = regs[rdSelA];
   assign rdDataB = regs[rdSelB];

endmodule

`default_nettype wire

//--- rtl/wbMaster.sv
`default_nettype none

module wbMaster (
   input  wire logic                         clk,
   input  wire logic                         arstN,
   input  wire logic                         busStart,
   input  wire logic                         busWe,
   input  wire logic [cpuPkg::dataWidth-1:0] busAdr,
   input  wire logic [cpuPkg::dataWidth-1:0] busWrData,
   output logic                              busDone,
   output logic      [cpuPkg::dataWidth-1:0] busRdData,
   output cpuPkg::wbReqT                     wbReq,
   input  cpuPkg::wbRspT                     wbRsp
);

   import cpuPkg::*;

   logic                 cycReg;
   logic                 weReg;
   logic [dataWidth-1:0] adrReg;
   logic [dataWidth-1:0] datReg;
   logic                 ackSeen;

   // Slave answer during an open cycle
   assign ackSeen = cycReg & wbRsp.ack;

   // Cycle control
   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         cycReg <= 1'b0;
         weReg <= 1'b0;
         busDone <= 1'b0;
      end else begin
         busDone <= ackSeen;
         if (busStart) begin
            cycReg <= 1'b1;
            weReg <= busWe;
         end else if (ackSeen) begin
            // Drop the cycle right after ack
            cycReg <= 1'b0;
            weReg <= 1'b0;
         end
      end
   end

   // Address and data held for the whole cycle
   always_ff @(posedge clk) begin
      if (busStart) begin
         adrReg <= busAdr;
         datReg <= busWrData;
      end
      // Read word captured on the ack edge
      if (ackSeen) begin
         busRdData <= wbRsp.datRd;
      end
   end

   // Classic single cycle, stb follows cyc
   always_comb begin
      wbReq.cyc = cycReg;
      wbReq.stb = cycReg;
      wbReq.we = weReg;
      wbReq.adr = adrReg;
      wbReq.datWr = datReg;
   end

endmodule

`default_nettype wire

//--- verif/cpuChecker.sv
`default_nettype none

module cpuChecker (
   input  wire logic     clk,
   input  wire logic     arstN,
   input  cpuPkg::wbReqT wbReq,
   input  cpuPkg::wbRspT wbRsp,
   input  wire logic     halted
);

   ////////////////////////////////////////
   // Wishbone classic protocol
   ////////////////////////////////////////

   // Cycle and strobe drop in the cycle after ack
   cycCloses: assert property (@(posedge clk) disable iff (!arstN)
      (wbReq.cyc && wbReq.stb && wbRsp.ack) |=> (!wbReq.cyc && !wbReq.stb))
      else $error("bus cycle still open after ack");

   // Request held until the slave answers
   reqHeld: assert property (@(posedge clk) disable iff (!arstN)
      (wbReq.cyc && wbReq.stb && !wbRsp.ack) |=>
         (wbReq.cyc && wbReq.stb && $stable(wbReq.we) && $stable(wbReq.adr)
          && $stable(wbReq.datWr)))
      else $error("bus request changed before ack");

   ////////////////////////////////////////
   // Halt behavior
   ////////////////////////////////////////

   // No bus traffic once stopped
   noBusHalted: assert property (@(posedge clk) disable iff (!arstN)
      halted |-> !wbReq.cyc)
      else $error("bus cycle open while halted");

   // Only reset leaves the halted state
   haltSticky: assert property (@(posedge clk) disable iff (!arstN)
      halted |=> halted)
      else $error("halted fell without reset");

endmodule

bind cpuTop cpuChecker i_cpuChecker (
   .clk, .arstN, .wbReq, .wbRsp, .halted
);

`default_nettype wire

//--- verif/cpuTb.sv
`default_nettype none

module cpuTb;

   import cpuPkg::*;

   localparam int numCases = 9;
   localparam int progLen = 8;
   localparam int maxStores = 4;
   localparam int memWords = 256;
   localparam int haltTimeout = 1000;
   localparam int idleCycles = 10;

   logic  clk = 1'b0;
   logic  arstN;
   wbReqT wbReq;
   wbRspT wbRsp = '0;
   logic  halted;

   // Program table with the stores each program must make
   logic [dataWidth-1:0] progWords [numCases][progLen];
   logic [dataWidth-1:0] expAdr [numCases][maxStores];
   logic [dataWidth-1:0] expDat [numCases][maxStores];
   int                   expCount [numCases];

   // Memory model state
   logic [dataWidth-1:0] mem [memWords];
   wbReqT                storeLog [$];
   int                   curCase;
   logic                 pending;
   int                   waitLeft;

   int valueErrors;
   int otherErrors;

   always #50 clk = ~clk;

   cpuTop i_cpuTop (
      .clk    (clk),
      .arstN  (arstN),
      .wbReq  (wbReq),
      .wbRsp  (wbRsp),
      .halted (halted)
   );

   ////////////////////////////////////////
   // Instruction encoding
   ////////////////////////////////////////

   // Op Rs Rd imm5 for the immediate group, LD and ST
   function automatic logic [dataWidth-1:0] immInstr(input opcodeT op, input logic [2:0] rs,
                                                     input logic [2:0] rd,
                                                     input logic [4:0] imm);
      return {op, rs, rd, imm};
   endfunction

   // Op Rs imm8 for LBI and the branches
   function automatic logic [dataWidth-1:0] byteInstr(input opcodeT op, input logic [2:0] rs,
                                                      input logic [7:0] imm);
      return {op, rs, imm};
   endfunction

   // Op and 11-bit displacement
   function automatic logic [dataWidth-1:0] jumpInstr(input opcodeT op,
                                                      input logic [10:0] disp);
      return {op, disp};
   endfunction

   function automatic logic [dataWidth-1:0] regInstr(input logic [2:0] rs, input logic [2:0] rt,
                                                     input logic [2:0] rd,
                                                     input logic [1:0] func);
      return {opAluR, rs, rt, rd, func};
   endfunction

   task automatic expectStore(input int c, input logic [dataWidth-1:0] adr,
                              input logic [dataWidth-1:0] dat);
      expAdr[c][expCount[c]] = adr;
      expDat[c][expCount[c]] = dat;
      expCount[c]++;
   endtask

   ////////////////////////////////////////
   // Stimulus table
   ////////////////////////////////////////

   task automatic fillCaseTable();
      // Unused words are HALT
      for (int c = 0; c < numCases; c++) begin
         expCount[c] = 0;
         for (int w = 0; w < progLen; w++) begin
            progWords[c][w] = {opHalt, 11'd0};
         end
         for (int s = 0; s < maxStores; s++) begin
            expAdr[c][s] = '0;
            expDat[c][s] = '0;
         end
      end
      // LBI sign extends, ST at Rs plus imm5
      progWords[0][0] = byteInstr(opLbi, 3'd1, 8'hF3);
      progWords[0][1] = byteInstr(opLbi, 3'd2, 8'h40);
      progWords[0][2] = immInstr(opSt, 3'd2, 3'd1, 5'd3);
      expectStore(0, 16'h0043, 16'hFFF3);
      // ADDI with -2, SUBI is imm minus Rs with -3
      progWords[1][0] = byteInstr(opLbi, 3'd1, 8'h25);
      progWords[1][1] = byteInstr(opLbi, 3'd2, 8'h50);
      progWords[1][2] = immInstr(opAddi, 3'd1, 3'd3, 5'h1E);
      progWords[1][3] = immInstr(opSt, 3'd2, 3'd3, 5'd0);
      progWords[1][4] = immInstr(opSubi, 3'd1, 3'd4, 5'h1D);
      progWords[1][5] = immInstr(opSt, 3'd2, 3'd4, 5'd1);
      expectStore(1, 16'h0050, 16'h0023);
      expectStore(1, 16'h0051, 16'hFFD8);
      // Logic immediates zero extended, bit 4 set on purpose
      progWords[2][0] = byteInstr(opLbi, 3'd1, 8'hA5);
      progWords[2][1] = byteInstr(opLbi, 3'd2, 8'h58);
      progWords[2][2] = immInstr(opXori, 3'd1, 3'd3, 5'h1C);
      progWords[2][3] = immInstr(opSt, 3'd2, 3'd3, 5'd0);
      progWords[2][4] = immInstr(opAndni, 3'd1, 3'd4, 5'h17);
      progWords[2][5] = immInstr(opSt, 3'd2, 3'd4, 5'd1);
      expectStore(2, 16'h0058, 16'hFFB9);
      expectStore(2, 16'h0059, 16'hFFA0);
      // Register ADD and SUB, SUB is Rt minus Rs
      progWords[3][0] = byteInstr(opLbi, 3'd1, 8'h34);
      progWords[3][1] = byteInstr(opLbi, 3'd2, 8'h81);
      progWords[3][2] = byteInstr(opLbi, 3'd5, 8'h60);
      progWords[3][3] = regInstr(3'd1, 3'd2, 3'd3, 2'b00);
      progWords[3][4] = immInstr(opSt, 3'd5, 3'd3, 5'd0);
      progWords[3][5] = regInstr(3'd1, 3'd2, 3'd4, 2'b01);
      progWords[3][6] = immInstr(opSt, 3'd5, 3'd4, 5'd1);
      expectStore(3, 16'h0060, 16'hFFB5);
      expectStore(3, 16'h0061, 16'hFF4D);
      // Register XOR and ANDN
      progWords[4][0] = byteInstr(opLbi, 3'd1, 8'h3C);
      progWords[4][1] = byteInstr(opLbi, 3'd2, 8'h96);
      progWords[4][2] = byteInstr(opLbi, 3'd5, 8'h68);
      progWords[4][3] = regInstr(3'd1, 3'd2, 3'd3, 2'b10);
      progWords[4][4] = immInstr(opSt, 3'd5, 3'd3, 5'd0);
      progWords[4][5] = regInstr(3'd1, 3'd2, 3'd4, 2'b11);
      progWords[4][6] = immInstr(opSt, 3'd5, 3'd4, 5'd1);
      expectStore(4, 16'h0068, 16'hFFAA);
      expectStore(4, 16'h0069, 16'h0028);
      // LD of fill words, forward and backward offsets, after a NOP
      progWords[5][0] = byteInstr(opLbi, 3'd1, 8'h70);
      progWords[5][1] = {opNop, 11'd0};
      progWords[5][2] = immInstr(opLd, 3'd1, 3'd2, 5'd5);
      progWords[5][3] = immInstr(opSt, 3'd1, 3'd2, 5'd6);
      progWords[5][4] = immInstr(opLd, 3'd1, 3'd3, 5'h1F);
      progWords[5][5] = immInstr(opSt, 3'd1, 3'd3, 5'd7);
      expectStore(5, 16'h0076, 16'h758A);
      expectStore(5, 16'h0077, 16'h6F90);
      // BEQZ taken and not taken, BNEZ taken
      progWords[6][0] = byteInstr(opLbi, 3'd1, 8'h7A);
      progWords[6][1] = byteInstr(opBeqz, 3'd0, 8'd1);
      progWords[6][2] = immInstr(opSt, 3'd1, 3'd1, 5'd0);
      progWords[6][3] = byteInstr(opBeqz, 3'd1, 8'd1);
      progWords[6][4] = immInstr(opSt, 3'd1, 3'd1, 5'd1);
      progWords[6][5] = byteInstr(opBnez, 3'd1, 8'd1);
      progWords[6][6] = immInstr(opSt, 3'd1, 3'd1, 5'd2);
      expectStore(6, 16'h007B, 16'h007A);
      // BNEZ not taken, J over one store
      progWords[7][0] = byteInstr(opLbi, 3'd1, 8'h7C);
      progWords[7][1] = byteInstr(opBnez, 3'd0, 8'd1);
      progWords[7][2] = immInstr(opSt, 3'd1, 3'd1, 5'd0);
      progWords[7][3] = jumpInstr(opJ, 11'd1);
      progWords[7][4] = immInstr(opSt, 3'd1, 3'd1, 5'd1);
      progWords[7][5] = immInstr(opSt, 3'd1, 3'd1, 5'd2);
      expectStore(7, 16'h007C, 16'h007C);
      expectStore(7, 16'h007E, 16'h007C);
      // J forward, then JAL back, R7 holds JAL address plus one
      progWords[8][0] = byteInstr(opLbi, 3'd1, 8'h30);
      progWords[8][1] = jumpInstr(opJ, 11'd3);
      progWords[8][2] = immInstr(opSt, 3'd1, 3'd7, 5'd2);
      progWords[8][4] = immInstr(opSt, 3'd1, 3'd1, 5'd0);
      progWords[8][5] = jumpInstr(opJal, 11'h7FC);
      progWords[8][6] = immInstr(opSt, 3'd1, 3'd1, 5'd1);
      expectStore(8, 16'h0032, 16'h0006);
   endtask

   ////////////////////////////////////////
   // Wishbone memory model
   ////////////////////////////////////////

   // Answers after 0 to 2 wait cycles, loads the current program in reset
   always @(negedge clk) begin
      if (!arstN) begin
         wbRsp = '0;
         pending = 1'b0;
         waitLeft = 0;
         // Fill word is the address and its inverse
         for (int a = 0; a < memWords; a++) begin
            mem[a] = {8'(a), ~8'(a)};
         end
         for (int a = 0; a < progLen; a++) begin
            mem[a] = progWords[curCase][a];
         end
         storeLog.delete();
      end else if (wbRsp.ack) begin
         // Master closes the cycle on the ack edge
         wbRsp.ack = 1'b0;
      end else if (wbReq.cyc && wbReq.stb) begin
         if (!pending) begin
            pending = 1'b1;
            waitLeft = $urandom % 3;
         end
         if (waitLeft == 0) begin
            pending = 1'b0;
            if (wbReq.we) begin
               mem[wbReq.adr[7:0]] = wbReq.datWr;
               storeLog.push_back(wbReq);
               wbRsp.datRd = '0;
            end else begin
               wbRsp.datRd = mem[wbReq.adr[7:0]];
            end
            wbRsp.ack = 1'b1;
         end else begin
            waitLeft = waitLeft - 1;
         end
      end
   end

   ////////////////////////////////////////
   // Checks
   ////////////////////////////////////////

   task automatic checkStore(input wbReqT got, input logic [dataWidth-1:0] wantAdr,
                             input logic [dataWidth-1:0] wantDat);
      if (got.adr !== wantAdr) begin
         $display("** Error at %0t: wbReq.adr = %h, expected %h", $time, got.adr, wantAdr);
         valueErrors++;
      end
      if (got.datWr !== wantDat) begin
         $display("** Error at %0t: wbReq.datWr = %h, expected %h", $time, got.datWr,
                  wantDat);
         valueErrors++;
      end
   endtask

   task automatic checkHalt(input int c, input logic gotHalt, input logic heldHalt,
                            input int busAfter, input int gotStores, input int wantStores);
      if (!gotHalt) begin
         $display("Case %0d: the core did not halt within %0d cycles", c, haltTimeout);
         otherErrors++;
      end
      if (!heldHalt) begin
         $display("Case %0d: halted dropped again without a reset", c);
         otherErrors++;
      end
      if (busAfter != 0) begin
         $display("Case %0d: bus was active for %0d cycles after halt", c, busAfter);
         otherErrors++;
      end
      if (gotStores != wantStores) begin
         $display("Case %0d: %0d stores seen but %0d expected", c, gotStores, wantStores);
         otherErrors++;
      end
   endtask

   ////////////////////////////////////////
   // Main sequence
   ////////////////////////////////////////

   initial begin
      int   cycles;
      int   busAfter;
      logic gotHalt;
      logic heldHalt;
      void'($urandom(32'he81b));
      arstN = 1'b0;
      curCase = 0;
      valueErrors = 0;
      otherErrors = 0;
      fillCaseTable();
      for (int c = 0; c < numCases; c++) begin
         @(negedge clk);
         curCase = c;
         arstN = 1'b0;
         repeat (5) @(negedge clk);
         arstN = 1'b1;
         // Run until HALT
         cycles = 0;
         while (!halted && cycles < haltTimeout) begin
            @(negedge clk);
            cycles++;
         end
         gotHalt = halted;
         heldHalt = 1'b1;
         busAfter = 0;
         // Core must stay quiet after halt
         if (gotHalt) begin
            repeat (idleCycles) begin
               @(negedge clk);
               if (!halted) heldHalt = 1'b0;
               if (wbReq.cyc) busAfter++;
            end
         end
         checkHalt(c, gotHalt, heldHalt, busAfter, storeLog.size(), expCount[c]);
         for (int s = 0; s < storeLog.size() && s < maxStores; s++) begin
            checkStore(storeLog[s], expAdr[c][s], expDat[c][s]);
         end
      end
      $display("Cases: %0d, value errors: %0d, other errors: %0d", numCases, valueErrors,
               otherErrors);
      if (valueErrors + otherErrors == 0) begin
         $display("** PASS **");
      end else begin
         $display("** FAIL **");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- verilog.f
rtl/cpuPkg.sv
rtl/regFile.sv
rtl/decode.sv
rtl/alu.sv
rtl/wbMaster.sv
rtl/cpuSequencer.sv
rtl/cpuTop.sv
verif/cpuChecker.sv
verif/cpuTb.sv
